// File: Makefile
# Verilator flow for the e^x Taylor engine

VERILATOR ?= verilator
TOP       ?= exp_taylor_tb
FILELIST  ?= exp_taylor.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: exp_taylor.f
hw/exp_taylor_pkg.sv
hw/horner_ctrl_if.sv
hw/horner_sequencer.sv
hw/horner_datapath.sv
hw/exp_taylor_top.sv
sim/exp_taylor_props.sv
sim/exp_taylor_checker.sv
sim/exp_taylor_tb.sv

// File: hw/exp_taylor_pkg.sv
package exp_taylor_pkg;

    // ------------------------------------------------------------------------
    // fixed-point formats
    // ------------------------------------------------------------------------

    // x is unsigned Q2.14
    localparam int WIDTH_X = 16;
    localparam int FRAC_X = 14;

    // accumulator and result are Q7.25
    localparam int WIDTH_Y = 32;
    localparam int FRAC_Y = 25;

    // shift taking a Q2.14 coefficient up to Q7.25
    localparam int COEF_ALIGN = FRAC_Y - FRAC_X;

    // highest coefficient index, a5
    localparam int N_TERMS = 5;

    typedef logic [WIDTH_X-1:0] x_t;
    typedef logic [WIDTH_Y-1:0] y_t;

    // Q7.25 times Q2.14 lands in Q9.39
    typedef logic [WIDTH_Y+WIDTH_X-1:0] prod_t;

    // wide enough for 0 to N_TERMS
    typedef logic [2:0] coef_idx_t;

    // ------------------------------------------------------------------------
    // taylor coefficients of e^x, Q2.14, truncated
    // ------------------------------------------------------------------------
    localparam x_t COEF [0:N_TERMS] = '{
        16'h4000,   // a0 = 1
        16'h4000,   // a1 = 1
        16'h2000,   // a2 = 1/2
        16'h0aaa,   // a3 = 1/6
        16'h02aa,   // a4 = 1/24
        16'h0088    // a5 = 1/120
    };

    // ------------------------------------------------------------------------
    // sequencer states
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        MUL  = 2'd1,
        ADD  = 2'd2,
        DONE = 2'd3
    } seq_state_t;

endpackage

// File: hw/exp_taylor_top.sv
`timescale 1ns/1ps

// e^x by a fifth-order taylor polynomial
// x in Q2.14, result in Q7.25, one item at a time
module exp_taylor_top import exp_taylor_pkg::*; (
    input  logic clk,
    input  logic reset,

    // input stream
    input  logic i_valid,
    input  x_t   i_x,
    output logic o_ready,

    // output stream
    output logic o_valid,
    output y_t   o_y,
    input  logic i_ready
);

    // ------------------------------------------------------------------------
    // control bundle between sequencer and datapath
    // ------------------------------------------------------------------------
    horner_ctrl_if ctrl_if ();

    // ------------------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------------------

    // handshake lives here, nowhere else
    horner_sequencer seq_i (
        .clk     (clk),
        .reset   (reset),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_ready (i_ready),
        .o_valid (o_valid),
        .ctrl    (ctrl_if.seq)
    );

    // ------------------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------------------

    // operand in, accumulator out
    horner_datapath dp_i (
        .clk   (clk),
        .reset (reset),
        .i_x   (i_x),
        .o_y   (o_y),
        .ctrl  (ctrl_if.dp)
    );

endmodule

// File: hw/horner_ctrl_if.sv
`timescale 1ns/1ps

// control strobes from the sequencer into the datapath
// every signal is a one-cycle level, no handshake of its own
interface horner_ctrl_if import exp_taylor_pkg::*; ();

    // capture x, preset accumulator to a5 aligned
    logic load;

    // register rescaled acc * x
    logic mul_en;

    // acc <= product + aligned coef[term]
    logic add_en;

    // coefficient index for the add
    coef_idx_t term;

    // sequencer side drives everything
    modport seq (
        output load,
        output mul_en,
        output add_en,
        output term
    );

    // datapath side only listens
    modport dp (
        input load,
        input mul_en,
        input add_en,
        input term
    );

endinterface

// File: hw/horner_datapath.sv
`timescale 1ns/1ps

// shared multiplier and adder for the horner evaluation
// acc <- a5, then five times acc <- acc * x + a[k]
module horner_datapath import exp_taylor_pkg::*; (
    input  logic clk,
    input  logic reset,

    // operand, sampled on load
    input  x_t   i_x,

    // accumulator straight out
    output y_t   o_y,

    // strobes from the sequencer
    horner_ctrl_if.dp ctrl
);

    // ------------------------------------------------------------------------
    // storage
    // ------------------------------------------------------------------------

    // operand held for the whole evaluation
    x_t x_q;

    // running Q7.25 value
    y_t acc_q;

    // rescaled product between mul and add
    y_t prod_q;

    // ------------------------------------------------------------------------
    // combinational paths
    // ------------------------------------------------------------------------

    // Q7.25 * Q2.14, full 48 bits in Q9.39
    prod_t full_prod;

    // back to Q7.25
    y_t prod_rescaled;

    // coefficient picked by term, already in Q7.25
    y_t coef_aligned;

    // a5 in Q7.25, the starting value
    y_t coef_top;

    // product plus coefficient, wraps at 32 bits
    y_t sum;

    // zero-extend a Q2.14 coefficient and line up the binary point
    function automatic y_t align_coef(input x_t c);
        y_t wide;
        wide = y_t'(c);
        return wide << COEF_ALIGN;
    endfunction

    // unsigned, both operands widened first
    assign full_prod = prod_t'(acc_q) * prod_t'(x_q);

    // drop 14 lsbs and the top 2 integer bits
    assign prod_rescaled = full_prod[FRAC_X +: WIDTH_Y];

    assign coef_aligned = align_coef(COEF[ctrl.term]);
    assign coef_top     = align_coef(COEF[N_TERMS]);

    // overflow wraps, only the low 32 bits survive
    assign sum = prod_q + coef_aligned;

    // ------------------------------------------------------------------------
    // operand and accumulator
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            x_q   <= '0;
            acc_q <= '0;
        end else begin
            if (ctrl.load) begin
                x_q   <= i_x;
                acc_q <= coef_top;
            end else if (ctrl.add_en) begin
                acc_q <= sum;
            end
        end
    end

    // product stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prod_q <= '0;
        end else if (ctrl.mul_en) begin
            prod_q <= prod_rescaled;
        end
    end

    // result is whatever the accumulator holds
    assign o_y = acc_q;

endmodule

// File: hw/horner_sequencer.sv
`timescale 1ns/1ps

// horner schedule for a fifth-order polynomial
// one input in flight, five mul/add pairs, result held until taken
module horner_sequencer import exp_taylor_pkg::*; (
    input  logic clk,
    input  logic reset,

    // upstream side
    input  logic i_valid,
    output logic o_ready,

    // downstream side
    input  logic i_ready,
    output logic o_valid,

    // strobes to the datapath
    horner_ctrl_if.seq ctrl
);

    // ------------------------------------------------------------------------
    // state and term counter
    // ------------------------------------------------------------------------
    seq_state_t state_q;
    seq_state_t state_d;

    // coefficient index of the next add, counts down
    coef_idx_t term_q;
    coef_idx_t term_d;

    // handshake events
    logic accept;
    logic release_y;

    // final add of the chain, a0
    logic last_term;

    // ------------------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------------------

    // idle is the only state that can take a new x
    assign o_ready = (state_q == IDLE);

    // result sits on o_y for the whole of DONE
    assign o_valid = (state_q == DONE);

    // the one place the input handshake is decided
    assign accept = o_ready && i_valid;

    // downstream has taken the result
    assign release_y = o_valid && i_ready;

    assign last_term = (term_q == '0);

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        term_d  = term_q;

        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = MUL;
                    // a5 goes straight into the accumulator, so start at a4
                    term_d  = coef_idx_t'(N_TERMS - 1);
                end
            end

            MUL: begin
                state_d = ADD;
            end

            ADD: begin
                if (last_term) begin
                    state_d = DONE;
                end else begin
                    state_d = MUL;
                    term_d  = term_q - 1'b1;
                end
            end

            DONE: begin
                // stall here as long as downstream holds off
                if (release_y) begin
                    state_d = IDLE;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= IDLE;
            term_q  <= '0;
        end else begin
            state_q <= state_d;
            term_q  <= term_d;
        end
    end

    // ------------------------------------------------------------------------
    // datapath strobes
    // ------------------------------------------------------------------------

    // load fires in the acceptance cycle itself
    assign ctrl.load = accept;

    // mul and add alternate, one cycle each
    assign ctrl.mul_en = (state_q == MUL);
    assign ctrl.add_en = (state_q == ADD);

    // only looked at while add_en is high
    assign ctrl.term = term_q;

endmodule

// File: sim/exp_taylor_checker.sv
`timescale 1ns/1ps

// watches the DUT ports, predicts each result and compares
module exp_taylor_checker import exp_taylor_pkg::*; (
    input logic clk,
    input logic reset,
    input logic i_valid,
    input x_t   i_x,
    input logic o_ready,
    input logic o_valid,
    input y_t   o_y,
    input logic i_ready
);

    int pass_count = 0;
    int fail_count = 0;

    // one entry per accepted input, oldest first
    y_t exp_q[$];
    x_t x_q[$];
    int acc_cyc_q[$];

    int   cycle = 0;
    int   test_no = 0;
    logic valid_d = 1'b0;
    logic ready_d = 1'b0;
    y_t   y_d = '0;
    logic item_err = 1'b0;

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    // a_k = 1/k!, truncated to Q2.14, then moved to Q7.25
    function automatic y_t coef_q25(input int k);
        int unsigned f;
        int i;
        f = 1;
        for (i = 2; i <= k; i++) begin
            f = f * i;
        end
        return y_t'(((1 << FRAC_X) / f) << (FRAC_Y - FRAC_X));
    endfunction

    // horner, rescale each product by 2^-14, keep 32 bits
    function automatic y_t exp_ref(input x_t x);
        logic [63:0] acc;
        logic [63:0] prod;
        int k;
        acc = 64'(coef_q25(N_TERMS));
        for (k = N_TERMS - 1; k >= 0; k--) begin
            prod = acc * 64'(x);
            acc  = ((prod >> FRAC_X) + 64'(coef_q25(k))) & 64'h0000_0000_ffff_ffff;
        end
        return y_t'(acc);
    endfunction

    task automatic report_value(input string sig, input y_t got, input y_t exp);
        $display("[FAIL] %0t %s: got %h, expected %h", $time, sig, got, exp);
    endtask

    // ------------------------------------------------------------------------
    // reset state
    // ------------------------------------------------------------------------
    always @(negedge reset) begin
        if (o_valid !== 1'b0 || o_ready !== 1'b1) begin
            $display("[FAIL] %0t o_valid/o_ready: got %b/%b, expected 0/1",
                     $time, o_valid, o_ready);
            fail_count++;
        end else begin
            $display("[PASS] reset state");
            pass_count++;
        end
    end

    // result taken, compare and report the test
    task automatic finish_item();
        y_t exp;
        x_t x;
        if (exp_q.size() == 0) begin
            $display("[FAIL] %0t: result released with no accepted input", $time);
            fail_count++;
        end else begin
            exp = exp_q.pop_front();
            x   = x_q.pop_front();
            void'(acc_cyc_q.pop_front());
            test_no++;
            if (o_y !== exp) begin
                report_value("o_y", o_y, exp);
                item_err = 1'b1;
            end
            // x = 0 must give exactly 1.0
            if (x == '0 && o_y !== (y_t'(1) << FRAC_Y)) begin
                report_value("o_y", o_y, y_t'(1) << FRAC_Y);
                item_err = 1'b1;
            end
            if (item_err) begin
                $display("test %0d x=%h: failed", test_no, x);
                fail_count++;
            end else begin
                $display("[PASS] test %0d x=%h y=%h", test_no, x, o_y);
                pass_count++;
            end
            item_err = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------------
    // per-edge checks
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (!reset) begin
            cycle++;
            if (o_ready && o_valid) begin
                $display("[FAIL] %0t: o_ready and o_valid both high", $time);
                fail_count++;
            end
            // stalled result must stay put
            if (valid_d && !ready_d) begin
                if (!o_valid) begin
                    $display("[FAIL] %0t: o_valid dropped while i_ready was low", $time);
                    item_err = 1'b1;
                end else if (o_y !== y_d) begin
                    report_value("o_y", o_y, y_d);
                    item_err = 1'b1;
                end
            end
            if (o_ready && i_valid) begin
                // one item at a time, nothing may be taken while busy
                if (exp_q.size() != 0) begin
                    $display("[FAIL] %0t: input accepted while a result was pending",
                             $time);
                    fail_count++;
                end
                exp_q.push_back(exp_ref(i_x));
                x_q.push_back(i_x);
                acc_cyc_q.push_back(cycle);
            end
            // latency from acceptance edge to the edge that raised o_valid
            // o_valid is first seen high one edge after it rose
            if (o_valid && !valid_d && acc_cyc_q.size() != 0) begin
                if (cycle - 1 - acc_cyc_q[0] != 2 * N_TERMS) begin
                    $display("[FAIL] %0t latency: got %0d, expected %0d",
                             $time, cycle - 1 - acc_cyc_q[0], 2 * N_TERMS);
                    item_err = 1'b1;
                end
            end
            if (o_valid && i_ready) begin
                finish_item();
            end
            valid_d = o_valid;
            ready_d = i_ready;
            y_d     = o_y;
        end
    end

endmodule

// File: sim/exp_taylor_props.sv
`timescale 1ns/1ps

// handshake and latency properties of the sequencer
module exp_taylor_props import exp_taylor_pkg::*; (
    input logic clk,
    input logic reset,
    input logic i_valid,
    input logic i_ready,
    input logic o_ready,
    input logic o_valid
);

    // idle and done never overlap
    assert property (@(posedge clk) disable iff (reset)
        !(o_ready && o_valid))
        else $error("o_ready and o_valid high in the same cycle");

    // five mul/add pairs after acceptance
    // o_valid flips on edge 10 and is sampled high on edge 11
    assert property (@(posedge clk) disable iff (reset)
        (o_ready && i_valid) |-> ##(2 * N_TERMS + 1) $rose(o_valid))
        else $error("o_valid missing at the expected latency");

    // no early result either
    assert property (@(posedge clk) disable iff (reset)
        $rose(o_valid) |-> $past(o_ready && i_valid, 2 * N_TERMS + 1))
        else $error("o_valid rose without an acceptance at the expected latency");

    // result held under back-pressure
    assert property (@(posedge clk) disable iff (reset)
        (o_valid && !i_ready) |=> o_valid)
        else $error("o_valid dropped while i_ready was low");

endmodule

bind horner_sequencer exp_taylor_props props_i (
    .clk     (clk),
    .reset   (reset),
    .i_valid (i_valid),
    .i_ready (i_ready),
    .o_ready (o_ready),
    .o_valid (o_valid)
);

// File: sim/exp_taylor_tb.sv
`timescale 1ns/1ps

module exp_taylor_tb import exp_taylor_pkg::*; ();

    // 44 items of at most 12 + 15 + 3 cycles, plus margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int N_RANDOM = 40;

    logic clk;
    logic reset;
    logic i_valid;
    x_t   i_x;
    logic i_ready;
    logic o_ready;
    logic o_valid;
    y_t   o_y;

    logic [15:0] lfsr_q;
    int cycle_cnt = 0;
    int sent_cnt = 0;
    int unsigned gap;
    int unsigned xv;
    int unsigned sv;

    exp_taylor_top dut_i (
        .clk     (clk),
        .reset   (reset),
        .i_valid (i_valid),
        .i_x     (i_x),
        .o_ready (o_ready),
        .o_valid (o_valid),
        .o_y     (o_y),
        .i_ready (i_ready)
    );

    exp_taylor_checker chk_i (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    // 16-bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output int unsigned v);
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // one transaction, stall = cycles of i_ready low during DONE
    task automatic run_item(input x_t x, input int stall);
        while (!o_ready) begin
            next_cycle();
        end
        i_valid = 1'b1;
        i_x     = x;
        i_ready = (stall == 0);
        next_cycle();
        // stalled items keep offering another x while busy
        // none of it may be taken
        i_valid = (stall > 0);
        i_x     = ~x;
        while (!o_valid) begin
            next_cycle();
        end
        if (stall > 0) begin
            repeat (stall) next_cycle();
            i_valid = 1'b0;
            i_ready = 1'b1;
        end
        while (o_valid) begin
            next_cycle();
        end
        sent_cnt++;
    endtask

    // ------------------------------------------------------------------------
    // run limit
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    initial begin
        reset   = 1'b1;
        i_valid = 1'b0;
        i_x     = '0;
        i_ready = 1'b0;
        lfsr_q  = 16'd62;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();

        // zero, 1.0, 0.5, max code
        run_item(16'h0000, 0);
        run_item(16'h4000, 0);
        run_item(16'h2000, 0);
        run_item(16'hffff, 0);

        // random x, idle gaps and back-pressure
        repeat (N_RANDOM) begin
            draw_bits(2, gap);
            repeat (gap) next_cycle();
            draw_bits(16, xv);
            draw_bits(4, sv);
            run_item(x_t'(xv), 1 + sv % 15);
        end
        repeat (3) next_cycle();

        $display("tests passed: %0d, failed: %0d", chk_i.pass_count, chk_i.fail_count);
        if (chk_i.pass_count + chk_i.fail_count != sent_cnt + 1) begin
            $display("checker saw %0d tests, %0d were run",
                     chk_i.pass_count + chk_i.fail_count, sent_cnt + 1);
        end
        if (chk_i.fail_count == 0 && chk_i.pass_count == sent_cnt + 1) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
